//--- include/sd_share_defines.svh
`ifndef SD_SHARE_DEFINES_SVH
`define SD_SHARE_DEFINES_SVH

//**************************************************************************
//* card sharing geometry
//**************************************************************************
`define SD_NCTRL       6         // controllers on the card
`define SD_BANK_W      4         // disk-bank switch width
`define SD_CARD_ADR_W  27        // card block address width
`define SD_OFS_W       22        // offset inside one bank

// disk array offsets inside a bank
`define SD_OFS_RK      22'h000000   // RK11
`define SD_OFS_DW      22'h00c000   // DW winchester
`define SD_OFS_DM      22'h330000   // RK611
`define SD_OFS_DB      22'h030000   // RH70
`define SD_OFS_DX      22'h02c000   // RX01
`define SD_OFS_MY      22'h02e000   // MY floppy

//**************************************************************************
//* card pins with no owner
//**************************************************************************
`define SD_IDLE_CS     1'b1      // card deselected
`define SD_IDLE_MOSI   1'b1      // line parked high
`define SD_IDLE_SCLK   1'b0      // clock parked low

`endif

//--- src/sd_share_pkg.sv
`include "sd_share_defines.svh"

package sd_share_pkg;

   //***********************************************************************
   //* vector types
   //***********************************************************************
   typedef logic [`SD_BANK_W-1:0]     disk_bank_t;   // disk-bank switch
   typedef logic [`SD_CARD_ADR_W-1:0] card_adr_t;    // start block on card
   typedef logic [`SD_NCTRL-1:0]      ctrl_vec_t;    // one bit per controller

   // controller id, lower value wins the card
   typedef enum logic [2:0] {
      CTRL_RK = 3'd0,   // RK11
      CTRL_DW = 3'd1,   // DW
      CTRL_DM = 3'd2,   // RK611
      CTRL_DB = 3'd3,   // RH70
      CTRL_DX = 3'd4,   // RX01
      CTRL_MY = 3'd5    // MY
   } ctrl_e;

   // arbiter FSM
   typedef enum logic {
      ARB_IDLE = 1'b0,  // card free
      ARB_HELD = 1'b1   // card owned
   } arb_state_e;

   // SPI lines from a controller toward the card
   typedef struct packed {
      logic cs;         // chip select, active low
      logic mosi;       // data to card
      logic sclk;       // serial clock
   } spi_lines_t;

endpackage

//--- src/sd_req_sync.sv
`timescale 1ns/1ps

module sd_req_sync import sd_share_pkg::*; (
   input  logic      sdclock,   // card clock
   input  logic      arst_n_i,  // async reset, active low
   input  ctrl_vec_t req_i,     // raw requests, any clock domain
   output ctrl_vec_t req_o      // filtered requests
);

   //***********************************************************************
   //* two flops per request bit
   //***********************************************************************
   ctrl_vec_t req_meta_q;  // first stage, may go metastable
   ctrl_vec_t req_sync_q;  // second stage, clean level

   always_ff @(posedge sdclock or negedge arst_n_i) begin
      if (!arst_n_i) begin
         req_meta_q <= '0;          // nobody asking
         req_sync_q <= '0;
      end else begin
         req_meta_q <= req_i;       // sample async levels
         req_sync_q <= req_meta_q;  // settle
      end
   end

   assign req_o = req_sync_q;       // two cycles behind req_i

endmodule

//--- src/sd_card_arbiter.sv
`timescale 1ns/1ps
`include "sd_share_defines.svh"

module sd_card_arbiter import sd_share_pkg::*; (
   input  logic                          sdclock,     // card clock
   input  logic                          arst_n_i,    // async reset, active low
   input  ctrl_vec_t                     req_i,       // filtered requests
   input  spi_lines_t [`SD_NCTRL-1:0]    ctrl_spi_i,  // lines of every controller
   output ctrl_vec_t                     grant_o,     // one-hot card permission
   output arb_state_e                    state_o,     // free or owned
   output ctrl_e                         owner_o,     // current owner
   output spi_lines_t                    card_o       // lines at the card pins
);

   // pin levels with no owner
   localparam spi_lines_t IDLE_LINES = '{
      cs:   `SD_IDLE_CS,
      mosi: `SD_IDLE_MOSI,
      sclk: `SD_IDLE_SCLK
   };

   arb_state_e state_q;    // arbiter FSM
   ctrl_e      owner_q;    // who holds the card
   ctrl_e      pick;       // best pending requester

   //***********************************************************************
   //* fixed priority pick
   //***********************************************************************
   always_comb begin
      pick = CTRL_RK;                           // default when nobody asks
      for (int i = `SD_NCTRL - 1; i >= 0; i--) begin
         if (req_i[i]) begin
            pick = ctrl_e'(i);                  // lowest index wins
         end
      end
   end

   //***********************************************************************
   //* ownership FSM
   //***********************************************************************
   always_ff @(posedge sdclock or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= ARB_IDLE;
         owner_q <= CTRL_RK;
      end else begin
         case (state_q)
            ARB_IDLE: begin
               if (req_i != '0) begin
                  state_q <= ARB_HELD;          // hand card to the pick
                  owner_q <= pick;
               end
            end
            ARB_HELD: begin
               if (!req_i[owner_q]) begin
                  state_q <= ARB_IDLE;          // owner let go
               end
            end
            default: state_q <= ARB_IDLE;
         endcase
      end
   end

   // grant decode of the owner
   always_comb begin
      grant_o = '0;
      if (state_q == ARB_HELD) begin
         grant_o[owner_q] = 1'b1;
      end
   end

   //***********************************************************************
   //* card line mux
   //***********************************************************************
   assign card_o  = (state_q == ARB_HELD) ? ctrl_spi_i[owner_q] : IDLE_LINES;
   assign state_o = state_q;
   assign owner_o = owner_q;

   // at most one controller on the card and only one that asked
   a_grant_onehot: assert property (
      @(posedge sdclock) disable iff (!arst_n_i)
      $onehot0(grant_o) && ((grant_o & ~$past(req_i)) == '0)
   );

   // no pre-emption while the owner still asks
   a_grant_kept: assert property (
      @(posedge sdclock) disable iff (!arst_n_i)
      ((grant_o & req_i) != '0) |=> (grant_o == $past(grant_o))
   );

   // owner frozen for the whole hold
   a_owner_stable: assert property (
      @(posedge sdclock) disable iff (!arst_n_i)
      (state_q == ARB_HELD) |=> (state_q == ARB_IDLE) || (owner_q == $past(owner_q))
   );

endmodule

//--- src/disk_map_cfg.sv
`timescale 1ns/1ps
`include "sd_share_defines.svh"

module disk_map_cfg import sd_share_pkg::*; (
   input  logic       sdclock,      // card clock
   input  logic       arst_n_i,     // async reset, active low
   input  disk_bank_t bank_i,       // disk-bank switch
   input  arb_state_e state_i,      // arbiter state
   input  ctrl_e      owner_i,      // arbiter owner
   output card_adr_t  card_base_o   // start block of owner's disks
);

   disk_bank_t bank_q;       // bank frozen during a transfer
   disk_bank_t bank_sel;     // bank applied to owner
   card_adr_t  card_base_q;

   // offset of each disk array inside a bank
   function automatic logic [`SD_OFS_W-1:0] ofs_of(input ctrl_e id);
      case (id)
         CTRL_RK: ofs_of = `SD_OFS_RK;
         CTRL_DW: ofs_of = `SD_OFS_DW;
         CTRL_DM: ofs_of = `SD_OFS_DM;
         CTRL_DB: ofs_of = `SD_OFS_DB;
         CTRL_DX: ofs_of = `SD_OFS_DX;
         CTRL_MY: ofs_of = `SD_OFS_MY;
         default: ofs_of = '0;
      endcase
   endfunction

   assign bank_sel = (owner_i == CTRL_DB) ? '0 : bank_q;  // DB lives in bank 0

   //***********************************************************************
   //* bank register and start offset
   //***********************************************************************
   always_ff @(posedge sdclock or negedge arst_n_i) begin
      if (!arst_n_i) begin
         bank_q      <= '0;
         card_base_q <= '0;
      end else begin
         if (state_i == ARB_IDLE) begin
            bank_q <= bank_i;                        // follow switch while free
         end
         if (state_i == ARB_HELD) begin
            card_base_q <= {1'b0, bank_sel, ofs_of(owner_i)};
         end else begin
            card_base_q <= '0;                       // no owner, no offset
         end
      end
   end

   assign card_base_o = card_base_q;

   // bank cannot move under a transfer
   a_bank_frozen: assert property (
      @(posedge sdclock) disable iff (!arst_n_i)
      (state_i == ARB_HELD) |=> $stable(bank_q)
   );

endmodule

//--- src/sd_card_share.sv
`timescale 1ns/1ps
`include "sd_share_defines.svh"

module sd_card_share import sd_share_pkg::*; (
   input  logic                          sdclock,        // card clock
   input  logic                          arst_n_i,       // async reset, active low

   // controller side
   input  ctrl_vec_t                     sd_req_i,       // raw card requests
   input  spi_lines_t [`SD_NCTRL-1:0]    ctrl_spi_i,     // lines per controller
   output ctrl_vec_t                     sd_grant_o,     // card permission

   // configuration
   input  disk_bank_t                    sw_diskbank_i,  // disk-bank switch

   // card side
   output spi_lines_t                    card_o,         // cs, mosi, sclk at pins
   output card_adr_t                     card_base_o,    // owner's start block

   // front panel
   output ctrl_vec_t                     led_o           // activity, active low
);

   ctrl_vec_t  req_filt;     // requests after filter
   arb_state_e arb_state;    // free or owned
   ctrl_e      arb_owner;    // who has the card

   //***********************************************************************
   //* request filter
   //***********************************************************************
   sd_req_sync sd_req_sync_inst (
      .sdclock  (sdclock),
      .arst_n_i (arst_n_i),
      .req_i    (sd_req_i),
      .req_o    (req_filt)
   );

   //***********************************************************************
   //* arbiter and line mux
   //***********************************************************************
   sd_card_arbiter sd_card_arbiter_inst (
      .sdclock    (sdclock),
      .arst_n_i   (arst_n_i),
      .req_i      (req_filt),
      .ctrl_spi_i (ctrl_spi_i),
      .grant_o    (sd_grant_o),
      .state_o    (arb_state),
      .owner_o    (arb_owner),
      .card_o     (card_o)
   );

   // bank and offset for the owner
   disk_map_cfg disk_map_cfg_inst (
      .sdclock     (sdclock),
      .arst_n_i    (arst_n_i),
      .bank_i      (sw_diskbank_i),
      .state_i     (arb_state),
      .owner_i     (arb_owner),
      .card_base_o (card_base_o)
   );

   assign led_o = ~sd_req_i;   // LED lit while controller asks

endmodule

//--- tb/tb_sd_card_share.sv
`timescale 1ns/1ps
`include "sd_share_defines.svh"

module tb_sd_card_share import sd_share_pkg::*; ();

   localparam int WAIT_LIMIT = 64;   // cycles before a wait gives up

   localparam spi_lines_t IDLE_LINES = '{
      cs:   `SD_IDLE_CS,
      mosi: `SD_IDLE_MOSI,
      sclk: `SD_IDLE_SCLK
   };

   // disk array offsets, indexed by controller id
   localparam logic [`SD_OFS_W-1:0] OFS_TABLE [`SD_NCTRL] = '{
      `SD_OFS_RK, `SD_OFS_DW, `SD_OFS_DM, `SD_OFS_DB, `SD_OFS_DX, `SD_OFS_MY
   };

   // expected state of the whole sharing block
   typedef struct packed {
      ctrl_vec_t  meta;   // first filter stage
      ctrl_vec_t  filt;   // filtered requests
      arb_state_e st;
      ctrl_e      own;
      disk_bank_t bank;   // latched bank
      card_adr_t  base;
   } model_t;

   logic                       sdclock;
   logic                       arst_n_i;
   ctrl_vec_t                  sd_req_i;
   spi_lines_t [`SD_NCTRL-1:0] ctrl_spi_i;
   disk_bank_t                 sw_diskbank_i;
   ctrl_vec_t                  sd_grant_o;
   spi_lines_t                 card_o;
   card_adr_t                  card_base_o;
   ctrl_vec_t                  led_o;

   model_t mdl;
   logic   chk_en;        // compare only once out of reset
   string  test_name;

   sd_card_share sd_card_share_inst (
      .sdclock       (sdclock),
      .arst_n_i      (arst_n_i),
      .sd_req_i      (sd_req_i),
      .ctrl_spi_i    (ctrl_spi_i),
      .sd_grant_o    (sd_grant_o),
      .sw_diskbank_i (sw_diskbank_i),
      .card_o        (card_o),
      .card_base_o   (card_base_o),
      .led_o         (led_o)
   );

   initial begin
      sdclock = 1'b0;
      forever #4 sdclock = ~sdclock;   // 8 ns period
   end

   //***************************************************************************
   //* reference model
   //***************************************************************************
   function automatic ctrl_e first_set(input ctrl_vec_t v);
      ctrl_e id;
      logic  found;
      id    = CTRL_RK;
      found = 1'b0;
      for (int i = 0; i < `SD_NCTRL; i++) begin
         if (v[i] && !found) begin
            id    = ctrl_e'(i);    // highest priority asker
            found = 1'b1;
         end
      end
      return id;
   endfunction

   function automatic ctrl_vec_t one_hot(input ctrl_e id);
      ctrl_vec_t v;
      v     = '0;
      v[id] = 1'b1;
      return v;
   endfunction

   // next state after one sdclock edge
   function automatic model_t ref_step(input model_t m, input ctrl_vec_t req,
                                       input disk_bank_t bank);
      model_t     n;
      disk_bank_t b;
      n      = m;
      n.meta = req;
      n.filt = m.meta;
      if (m.st == ARB_HELD) begin
         b      = (m.own == CTRL_DB) ? 4'h0 : m.bank;   // DB pinned to bank 0
         n.base = {1'b0, b, OFS_TABLE[int'(m.own)]};
         if (!m.filt[m.own]) n.st = ARB_IDLE;          // owner released
      end else begin
         n.base = '0;
         n.bank = bank;                                  // switch taken while free
         if (m.filt != '0) begin
            n.st  = ARB_HELD;
            n.own = first_set(m.filt);
         end
      end
      return n;
   endfunction

   always @(posedge sdclock or negedge arst_n_i) begin
      if (!arst_n_i) begin
         mdl.meta <= '0;
         mdl.filt <= '0;
         mdl.st   <= ARB_IDLE;
         mdl.own  <= CTRL_RK;
         mdl.bank <= '0;
         mdl.base <= '0;
      end else begin
         mdl <= ref_step(mdl, sd_req_i, sw_diskbank_i);
      end
   end

   //***************************************************************************
   //* checks
   //***************************************************************************
   task automatic stop_with_failure();
      $display("Errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_vec(input string what, input ctrl_vec_t exp, input ctrl_vec_t act);
      if (exp !== act) begin
         $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
         stop_with_failure();
      end
   endtask

   task automatic check_lines(input string what, input spi_lines_t exp,
                              input spi_lines_t act);
      if (exp !== act) begin
         $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
         stop_with_failure();
      end
   endtask

   task automatic check_adr(input string what, input card_adr_t exp, input card_adr_t act);
      if (exp !== act) begin
         $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
         stop_with_failure();
      end
   endtask

   // outputs settle mid cycle, inputs moved at +1 ns
   always @(negedge sdclock) begin
      if (arst_n_i && chk_en) begin
         check_vec("grant", (mdl.st == ARB_HELD) ? one_hot(mdl.own) : 6'h00, sd_grant_o);
         check_lines("card lines",
                     (mdl.st == ARB_HELD) ? ctrl_spi_i[mdl.own] : IDLE_LINES, card_o);
         check_adr("card base", mdl.base, card_base_o);
         check_vec("led", ~sd_req_i, led_o);
      end
   end

   //***************************************************************************
   //* stimulus helpers
   //***************************************************************************
   task automatic step(input int n);
      repeat (n) begin
         @(posedge sdclock);
         #1;                           // drive just after the edge
      end
   endtask

   task automatic wait_grant(input ctrl_e id);
      int n;
      n = 0;
      while (!sd_grant_o[id] && n < WAIT_LIMIT) begin
         step(1);
         n++;
      end
      if (!sd_grant_o[id]) begin
         $display("Timeout in %s: controller %0d never got the card", test_name, int'(id));
         stop_with_failure();
      end
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (sd_grant_o != '0 && n < WAIT_LIMIT) begin
         step(1);
         n++;
      end
      if (sd_grant_o != '0) begin
         $display("Timeout in %s: the card was never released", test_name);
         stop_with_failure();
      end
   endtask

   // distinct lines per controller, none equal to the parked pins
   task automatic pick_lines();
      logic [31:0] r;
      logic [7:0]  used;
      int          tries;
      used             = '0;
      used[IDLE_LINES] = 1'b1;
      for (int i = 0; i < `SD_NCTRL; i++) begin
         tries = 0;
         do begin
            r = $urandom;
            tries++;
         end while (used[r[2:0]] && tries < 1000);
         if (used[r[2:0]]) begin
            $display("Could not pick distinct line values for controller %0d", i);
            stop_with_failure();
         end
         used[r[2:0]]  = 1'b1;
         ctrl_spi_i[i] = r[2:0];
      end
   endtask

   // raise a set at once, serve and drop each owner in priority order
   task automatic serve_set(input ctrl_vec_t set);
      ctrl_vec_t left;
      left     = set;
      sd_req_i = left;
      for (int i = 0; i < `SD_NCTRL; i++) begin
         if (set[i]) begin
            wait_grant(ctrl_e'(i));
            check_vec("owner", one_hot(ctrl_e'(i)), sd_grant_o);
            step(2);
            left[i]  = 1'b0;
            sd_req_i = left;           // owner lets go
            wait_idle();
         end
      end
   endtask

   //***************************************************************************
   //* test sequence
   //***************************************************************************
   initial begin
      logic [31:0] r;
      void'($urandom(32'h97e7));
      arst_n_i      = 1'b0;
      sd_req_i      = '0;
      sw_diskbank_i = '0;
      ctrl_spi_i    = '0;
      chk_en        = 1'b0;
      test_name     = "reset";
      pick_lines();
      repeat (4) @(posedge sdclock);
      #1;
      arst_n_i = 1'b1;
      chk_en   = 1'b1;
      check_vec("grant", '0, sd_grant_o);
      check_lines("card lines", IDLE_LINES, card_o);
      check_adr("card base", '0, card_base_o);
      step(2);

      test_name = "single";
      for (int i = 0; i < `SD_NCTRL; i++) begin
         serve_set(one_hot(ctrl_e'(i)));
         step(1);
      end

      test_name = "all_at_once";
      serve_set(6'h3f);
      test_name = "random_sets";
      repeat (12) begin
         r             = $urandom;
         sw_diskbank_i = r[11:8];
         serve_set((r[5:0] == '0) ? 6'h21 : r[5:0]);
      end

      test_name = "no_preempt";
      sd_req_i  = one_hot(CTRL_DX);
      wait_grant(CTRL_DX);
      step(1);
      sd_req_i = one_hot(CTRL_DX) | one_hot(CTRL_RK);   // higher priority shows up
      step(6);
      check_vec("dx kept", one_hot(CTRL_DX), sd_grant_o);
      sd_req_i = one_hot(CTRL_RK);
      wait_idle();
      wait_grant(CTRL_RK);
      sd_req_i = '0;
      wait_idle();

      test_name     = "bank_freeze";
      sw_diskbank_i = 4'h5;
      step(2);
      sd_req_i = one_hot(CTRL_DM);
      wait_grant(CTRL_DM);
      step(2);
      sw_diskbank_i = 4'ha;            // moved during the transfer
      step(4);
      check_adr("dm base", {1'b0, 4'h5, `SD_OFS_DM}, card_base_o);
      sd_req_i = '0;
      wait_idle();
      step(2);
      sd_req_i = one_hot(CTRL_DB);
      wait_grant(CTRL_DB);
      step(1);
      check_adr("db base", {1'b0, 4'h0, `SD_OFS_DB}, card_base_o);
      sd_req_i = one_hot(CTRL_DW);
      wait_idle();
      wait_grant(CTRL_DW);
      step(1);
      check_adr("dw base", {1'b0, 4'ha, `SD_OFS_DW}, card_base_o);
      sd_req_i = '0;
      wait_idle();

      test_name = "random_churn";      // model checks every cycle
      repeat (40) begin
         r             = $urandom;
         sd_req_i      = r[5:0];
         sw_diskbank_i = r[11:8];
         step(int'(r[13:12]) + 1);
      end
      sd_req_i = '0;
      wait_idle();
      step(4);

      $display("No errors");
      $finish;
   end

endmodule

//--- list.f
+incdir+include
src/sd_share_pkg.sv
src/sd_req_sync.sv
src/sd_card_arbiter.sv
src/disk_map_cfg.sv
src/sd_card_share.sv
tb/tb_sd_card_share.sv

//--- Makefile
# Verilator flow for the SD card sharing block

VERILATOR ?= verilator
FILELIST  ?= list.f
TB_TOP    ?= tb_sd_card_share
RTL_TOP   ?= sd_card_share
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= No errors

SOURCES := $(wildcard src/*.sv) $(wildcard tb/*.sv) $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
